// ==== rtl/game_pkg.sv ====
// Shared bus widths and default sound ROM placement for the game core

package game_pkg;

    // SDRAM bank geometry
    localparam int SDRAM_AW = 22;
    localparam int SDRAM_DW = 16;

    // Main CPU program ROM, 16-bit words
    localparam int MAIN_AW = 18;

    // Sound CPU ROM, byte addressed
    localparam int SND_AW = 16;

    // Sound ROM sits above the main program inside the same bank
    localparam logic [SDRAM_AW-1:0] SND_OFFSET = 22'h080000;

endpackage

// ==== rtl/cen_gen.sv ====
// Pixel clock enables and fractional FM clock enable generator

module cen_gen #(
    parameter int FM_NUM = 3,
    parameter int FM_DEN = 40
) (
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,
    output logic pxl_cen,
    output logic fm_cen
);

    localparam int ACC_W = $clog2(FM_DEN + FM_NUM) + 1;

    logic [2:0]       cnt;
    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] acc_sum;

    assign acc_sum = acc + ACC_W'(FM_NUM);

    // Pixel enables from a free-running divider
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 3'd1;
            pxl2_cen <= (cnt[1:0] == 2'd3);
            pxl_cen  <= (cnt == 3'd7);
        end
    end

    // FM_NUM evenly spread pulses every FM_DEN clocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc    <= '0;
            fm_cen <= 1'b0;
        end else if (acc_sum >= ACC_W'(FM_DEN)) begin
            acc    <= acc_sum - ACC_W'(FM_DEN);
            fm_cen <= 1'b1;
        end else begin
            acc    <= acc_sum;
            fm_cen <= 1'b0;
        end
    end

    a_pxl_in_pxl2: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen |-> pxl2_cen)
        else $error("pxl_cen without pxl2_cen");

endmodule

// ==== rtl/snd_mapper.sv ====
// One-byte mailbox from the main CPU to the sound CPU with pending flag

module snd_mapper (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sndmap_wr,
    input  logic [7:0] sndmap_din,
    input  logic       sndmap_rd,
    output logic [7:0] sndmap_dout,
    output logic       sndmap_pbf
);

    logic [7:0] mbox;

    // Byte from the main side
    always_ff @(posedge clk) begin
        if (sndmap_wr) begin
            mbox <= sndmap_din;
        end
    end

    // Sound side sees the byte after its read strobe
    always_ff @(posedge clk) begin
        if (sndmap_rd) begin
            sndmap_dout <= mbox;
        end
    end

    // Pending flag where a new write beats a read in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sndmap_pbf <= 1'b0;
        end else if (sndmap_wr) begin
            sndmap_pbf <= 1'b1;
        end else if (sndmap_rd) begin
            sndmap_pbf <= 1'b0;
        end
    end

    a_pbf_clear: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(sndmap_pbf) |-> $past(sndmap_rd))
        else $error("sndmap_pbf cleared without a read");

endmodule

// ==== rtl/rom_slot.sv ====
// ROM client slot with a one-word cache, SDRAM request issue and payload select

module rom_slot #(
    parameter type data_t = logic [15:0],
    parameter int AW = 18,
    parameter logic [game_pkg::SDRAM_AW-1:0] OFFSET = '0,
    parameter int BYTE_ADDR = 0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cs,
    input  logic [AW-1:0]                 addr,
    input  logic                          gnt_ack,
    input  logic                          gnt_rdy,
    input  logic [game_pkg::SDRAM_DW-1:0] rd_data,
    output data_t                         data,
    output logic                          ok,
    output logic                          req,
    output logic [game_pkg::SDRAM_AW-1:0] req_addr
);

    logic [game_pkg::SDRAM_AW-1:0] word_addr;
    logic [game_pkg::SDRAM_AW-1:0] cache_addr;
    logic [game_pkg::SDRAM_DW-1:0] cache_data;
    logic [game_pkg::SDRAM_DW-1:0] sel_word;
    logic                          cache_valid;
    logic                          waiting;
    logic                          hit;
    logic                          fill_match;
    logic                          ok_q;

    // Byte clients drop bit 0 to get the word address
    assign word_addr  = OFFSET + game_pkg::SDRAM_AW'(addr >> BYTE_ADDR);
    assign hit        = cache_valid && (cache_addr == word_addr);
    assign fill_match = gnt_rdy && (req_addr == word_addr);

    // Odd byte addresses take the upper half of the word
    assign sel_word = (BYTE_ADDR != 0 && addr[0]) ? (cache_data >> 8) : cache_data;
    assign data     = data_t'(sel_word);
    assign ok       = ok_q && cs && hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ok_q <= 1'b0;
        end else begin
            ok_q <= cs && (hit || fill_match);
        end
    end

    // Request issue and wait for the data beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req         <= 1'b0;
            waiting     <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            if (cs && !hit && !req && !waiting) begin
                req <= 1'b1;
            end else if (req && gnt_ack) begin
                req     <= 1'b0;
                waiting <= 1'b1;
            end
            if (waiting && gnt_rdy) begin
                waiting     <= 1'b0;
                cache_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs && !hit && !req && !waiting) begin
            req_addr <= word_addr;
        end
        if (waiting && gnt_rdy) begin
            cache_addr <= req_addr;
            cache_data <= rd_data;
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req && !gnt_ack |=> req)
        else $error("req dropped before gnt_ack");

endmodule

// ==== rtl/bank_arb.sv ====
// Round-robin arbiter sharing one SDRAM bank between two ROM slots

module bank_arb (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          main_req,
    input  logic [game_pkg::SDRAM_AW-1:0] main_req_addr,
    input  logic                          snd_req,
    input  logic [game_pkg::SDRAM_AW-1:0] snd_req_addr,
    input  logic                          ba_ack,
    input  logic                          ba_rdy,
    output logic                          main_gnt_ack,
    output logic                          main_gnt_rdy,
    output logic                          snd_gnt_ack,
    output logic                          snd_gnt_rdy,
    output logic [game_pkg::SDRAM_AW-1:0] ba_addr,
    output logic                          ba_rd
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_t;

    state_t state;
    logic   sel_snd;
    logic   last_snd;
    logic   pick_main;

    // Main wins unless sound is waiting and main went last
    assign pick_main = main_req && (last_snd || !snd_req);

    assign ba_rd        = (state == ST_REQ);
    assign main_gnt_ack = ba_rd && ba_ack && !sel_snd;
    assign snd_gnt_ack  = ba_rd && ba_ack && sel_snd;
    assign main_gnt_rdy = (state == ST_WAIT) && ba_rdy && !sel_snd;
    assign snd_gnt_rdy  = (state == ST_WAIT) && ba_rdy && sel_snd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            sel_snd  <= 1'b0;
            last_snd <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (main_req || snd_req) begin
                        sel_snd  <= !pick_main;
                        last_snd <= !pick_main;
                        state    <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (ba_ack) begin
                        state <= ST_WAIT;
                    end
                end
                default: begin
                    if (ba_rdy) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Address held for the whole bank request
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            ba_addr <= pick_main ? main_req_addr : snd_req_addr;
        end
    end

    a_rdy_busy: assert property (@(posedge clk) disable iff (!rst_n)
        ba_rdy |-> state != ST_IDLE)
        else $error("ba_rdy while the arbiter is idle");

endmodule

// ==== rtl/arcade_game.sv ====
// Game core top with clock enables, sound mailbox, ROM slots and bank arbiter

module arcade_game #(
    parameter int FM_NUM = 3,
    parameter int FM_DEN = 40,
    parameter logic [game_pkg::SDRAM_AW-1:0] SND_BASE = game_pkg::SND_OFFSET
) (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic                          pxl2_cen,
    output logic                          pxl_cen,
    output logic                          fm_cen,
    // Main CPU program ROM
    input  logic                          main_cs,
    input  logic [game_pkg::MAIN_AW-1:0]  main_addr,
    output logic [15:0]                   main_data,
    output logic                          main_ok,
    // Sound CPU ROM
    input  logic                          snd_cs,
    input  logic [game_pkg::SND_AW-1:0]   snd_addr,
    output logic [7:0]                    snd_data,
    output logic                          snd_ok,
    // Main to sound mailbox
    input  logic                          sndmap_wr,
    input  logic [7:0]                    sndmap_din,
    input  logic                          sndmap_rd,
    output logic [7:0]                    sndmap_dout,
    output logic                          sndmap_pbf,
    // SDRAM bank
    output logic [game_pkg::SDRAM_AW-1:0] ba_addr,
    output logic                          ba_rd,
    input  logic                          ba_ack,
    input  logic                          ba_rdy,
    input  logic [15:0]                   data_read
);

    logic                          main_req;
    logic [game_pkg::SDRAM_AW-1:0] main_req_addr;
    logic                          main_gnt_ack;
    logic                          main_gnt_rdy;
    logic                          snd_req;
    logic [game_pkg::SDRAM_AW-1:0] snd_req_addr;
    logic                          snd_gnt_ack;
    logic                          snd_gnt_rdy;

    cen_gen #(
        .FM_NUM   ( FM_NUM   ),
        .FM_DEN   ( FM_DEN   )
    ) u_cen (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  ),
        .fm_cen   ( fm_cen   )
    );

    snd_mapper u_mapper (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .sndmap_wr   ( sndmap_wr   ),
        .sndmap_din  ( sndmap_din  ),
        .sndmap_rd   ( sndmap_rd   ),
        .sndmap_dout ( sndmap_dout ),
        .sndmap_pbf  ( sndmap_pbf  )
    );

    // Program ROM at the bottom of the bank
    rom_slot #(
        .data_t    ( logic [15:0]      ),
        .AW        ( game_pkg::MAIN_AW ),
        .OFFSET    ( '0                ),
        .BYTE_ADDR ( 0                 )
    ) u_main_slot (
        .clk       ( clk           ),
        .rst_n     ( rst_n         ),
        .cs        ( main_cs       ),
        .addr      ( main_addr     ),
        .gnt_ack   ( main_gnt_ack  ),
        .gnt_rdy   ( main_gnt_rdy  ),
        .rd_data   ( data_read     ),
        .data      ( main_data     ),
        .ok        ( main_ok       ),
        .req       ( main_req      ),
        .req_addr  ( main_req_addr )
    );

    rom_slot #(
        .data_t    ( logic [7:0]      ),
        .AW        ( game_pkg::SND_AW ),
        .OFFSET    ( SND_BASE         ),
        .BYTE_ADDR ( 1                )
    ) u_snd_slot (
        .clk       ( clk          ),
        .rst_n     ( rst_n        ),
        .cs        ( snd_cs       ),
        .addr      ( snd_addr     ),
        .gnt_ack   ( snd_gnt_ack  ),
        .gnt_rdy   ( snd_gnt_rdy  ),
        .rd_data   ( data_read    ),
        .data      ( snd_data     ),
        .ok        ( snd_ok       ),
        .req       ( snd_req      ),
        .req_addr  ( snd_req_addr )
    );

    bank_arb u_arb (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .main_req      ( main_req      ),
        .main_req_addr ( main_req_addr ),
        .snd_req       ( snd_req       ),
        .snd_req_addr  ( snd_req_addr  ),
        .ba_ack        ( ba_ack        ),
        .ba_rdy        ( ba_rdy        ),
        .main_gnt_ack  ( main_gnt_ack  ),
        .main_gnt_rdy  ( main_gnt_rdy  ),
        .snd_gnt_ack   ( snd_gnt_ack   ),
        .snd_gnt_rdy   ( snd_gnt_rdy   ),
        .ba_addr       ( ba_addr       ),
        .ba_rd         ( ba_rd         )
    );

endmodule

// ==== tb/sdram_bank_model.sv ====
// Behavioural SDRAM bank with random ack and data latency and address-derived data

module sdram_bank_model #(
    parameter int SEED = 17523
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ba_rd,
    input  logic [game_pkg::SDRAM_AW-1:0] ba_addr,
    output logic                          ba_ack,
    output logic                          ba_rdy,
    output logic [15:0]                   data_read
);

    integer                        seed = SEED;
    int                            wait_cycles;
    logic [game_pkg::SDRAM_AW-1:0] addr_q;

    // One read at a time with outputs changing on the falling edge
    initial begin
        ba_ack    = 1'b0;
        ba_rdy    = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (rst_n && ba_rd) begin
                wait_cycles = 1 + {$random(seed)} % 4;
                repeat (wait_cycles - 1) @(negedge clk);
                addr_q = ba_addr;
                ba_ack = 1'b1;
                @(negedge clk);
                ba_ack = 1'b0;
                wait_cycles = 1 + {$random(seed)} % 6;
                repeat (wait_cycles - 1) @(negedge clk);
                data_read = addr_q[15:0] ^ 16'hA5C3;
                ba_rdy    = 1'b1;
                @(negedge clk);
                ba_rdy = 1'b0;
            end
        end
    end

endmodule

// ==== tb/tb_arcade_game.sv ====
// Game core testbench with clock, reset, stimulus, checks and result report

module tb_arcade_game;

    localparam int PERIOD  = 100;
    localparam int TIMEOUT = 200;

    logic                          clk;
    logic                          rst_n;
    logic                          pxl2_cen;
    logic                          pxl_cen;
    logic                          fm_cen;
    logic                          main_cs;
    logic [game_pkg::MAIN_AW-1:0]  main_addr;
    logic [15:0]                   main_data;
    logic                          main_ok;
    logic                          snd_cs;
    logic [game_pkg::SND_AW-1:0]   snd_addr;
    logic [7:0]                    snd_data;
    logic                          snd_ok;
    logic                          sndmap_wr;
    logic [7:0]                    sndmap_din;
    logic                          sndmap_rd;
    logic [7:0]                    sndmap_dout;
    logic                          sndmap_pbf;
    logic [game_pkg::SDRAM_AW-1:0] ba_addr;
    logic                          ba_rd;
    logic                          ba_ack;
    logic                          ba_rdy;
    logic [15:0]                   data_read;

    integer seed = 17523;
    int     errors;
    int     tests;
    int     base_errors;
    int     outstanding;
    int     rd_starts;
    logic   ba_rd_q;
    bit     timed_out;
    string  test_name;

    logic [game_pkg::MAIN_AW-1:0] pair_main_addr;
    logic [game_pkg::SND_AW-1:0]  pair_snd_addr;

    arcade_game #(.FM_NUM(3), .FM_DEN(40)) dut (.*);

    sdram_bank_model #(.SEED(17523)) u_bank (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Bank traffic bookkeeping
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 0;
            rd_starts   <= 0;
            ba_rd_q     <= 1'b0;
        end else begin
            ba_rd_q     <= ba_rd;
            rd_starts   <= rd_starts + int'(ba_rd && !ba_rd_q);
            outstanding <= outstanding + int'(ba_rd && ba_ack) - int'(ba_rdy);
        end
    end

    task automatic report_fail(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("FAIL %s: %s expected %0h actual %0h", test_name, what, exp, act);
        errors++;
    endtask

    task automatic check_equal(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else report_fail(what, exp, act);
    endtask

    a_main_idle: assert property (@(posedge clk) disable iff (!rst_n) !main_cs |-> !main_ok)
        else report_fail("main_ok with main_cs low", 0, main_ok);
    a_snd_idle: assert property (@(posedge clk) disable iff (!rst_n) !snd_cs |-> !snd_ok)
        else report_fail("snd_ok with snd_cs low", 0, snd_ok);
    a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
        ba_rd |-> outstanding == 0)
        else report_fail("reads outstanding while ba_rd is high", 0, outstanding);
    a_rdy_owed: assert property (@(posedge clk) disable iff (!rst_n)
        ba_rdy |-> outstanding == 1)
        else report_fail("reads outstanding at rdy", 1, outstanding);
    a_pbf_set: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sndmap_pbf) |-> $past(sndmap_wr))
        else report_fail("write before pbf rise", 1, 0);
    a_pbf_clr: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(sndmap_pbf) |-> $past(sndmap_rd))
        else report_fail("read before pbf fall", 1, 0);

    function automatic logic [15:0] rom_word(input logic [game_pkg::SDRAM_AW-1:0] waddr);
        return waddr[15:0] ^ 16'hA5C3;
    endfunction

    function automatic logic [7:0] sound_byte(input logic [game_pkg::SND_AW-1:0] baddr);
        logic [15:0] w;
        w = rom_word(game_pkg::SND_OFFSET + game_pkg::SDRAM_AW'(baddr >> 1));
        return baddr[0] ? w[15:8] : w[7:0];
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        base_errors = errors;
    endtask

    task automatic finish_test();
        tests++;
        $display("%-14s %s", test_name, (errors == base_errors) ? "passed" : "failed");
    endtask

    task automatic fetch_main(input logic [game_pkg::MAIN_AW-1:0] a);
        int i;
        main_cs   = 1'b1;
        main_addr = a;
        i         = 0;
        @(negedge clk);
        while (!main_ok && i < TIMEOUT) begin
            @(negedge clk);
            i++;
        end
        if (!main_ok) begin
            $display("Timeout in %s: main_ok never rose for address %h", test_name, a);
            timed_out = 1'b1;
            errors++;
        end else begin
            check_equal("main_data", rom_word(game_pkg::SDRAM_AW'(a)), main_data);
        end
        main_cs = 1'b0;
        @(negedge clk);
    endtask

    task automatic fetch_sound(input logic [game_pkg::SND_AW-1:0] a);
        int i;
        snd_cs   = 1'b1;
        snd_addr = a;
        i        = 0;
        @(negedge clk);
        while (!snd_ok && i < TIMEOUT) begin
            @(negedge clk);
            i++;
        end
        if (!snd_ok) begin
            $display("Timeout in %s: snd_ok never rose for address %h", test_name, a);
            timed_out = 1'b1;
            errors++;
        end else begin
            check_equal("snd_data", sound_byte(a), snd_data);
        end
        snd_cs = 1'b0;
        @(negedge clk);
    endtask

    task automatic count_clock_enables();
        int n2;
        int n1;
        int nf;
        start_test("clock_enables");
        n2 = 0;
        n1 = 0;
        nf = 0;
        repeat (800) begin
            @(negedge clk);
            n2 += int'(pxl2_cen);
            n1 += int'(pxl_cen);
            nf += int'(fm_cen);
            if (pxl_cen) check_equal("pxl2_cen with pxl_cen", 1, pxl2_cen);
        end
        check_equal("pxl2_cen count", 200, n2);
        check_equal("pxl_cen count", 100, n1);
        check_equal("fm_cen count", 60, nf);
        finish_test();
    endtask

    task automatic check_cache_hit();
        logic [game_pkg::MAIN_AW-1:0] a;
        int                           starts;
        start_test("cache_hit");
        a = game_pkg::MAIN_AW'($random(seed));
        fetch_main(a);
        starts    = rd_starts;
        main_cs   = 1'b1;
        main_addr = a;
        #(PERIOD / 4);
        check_equal("main_ok in the cs cycle", 0, main_ok);
        @(negedge clk);
        check_equal("main_ok one cycle after cs", 1, main_ok);
        check_equal("main_data on hit", rom_word(game_pkg::SDRAM_AW'(a)), main_data);
        repeat (4) @(negedge clk);
        check_equal("ba_rd starts during hit", starts, rd_starts);
        main_cs = 1'b0;
        @(negedge clk);
        finish_test();
    endtask

    task automatic exercise_mailbox();
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        start_test("mailbox");
        b0 = 8'($random(seed));
        b1 = 8'($random(seed));
        b2 = 8'($random(seed));
        check_equal("pbf before write", 0, sndmap_pbf);
        sndmap_wr  = 1'b1;
        sndmap_din = b0;
        @(negedge clk);
        sndmap_wr = 1'b0;
        check_equal("pbf after write", 1, sndmap_pbf);
        sndmap_rd = 1'b1;
        @(negedge clk);
        sndmap_rd = 1'b0;
        check_equal("sndmap_dout after read", b0, sndmap_dout);
        check_equal("pbf after read", 0, sndmap_pbf);
        sndmap_wr  = 1'b1;
        sndmap_din = b1;
        @(negedge clk);
        // Second write lands together with a read
        sndmap_din = b2;
        sndmap_rd  = 1'b1;
        @(negedge clk);
        sndmap_wr = 1'b0;
        sndmap_rd = 1'b0;
        check_equal("pbf after write with read", 1, sndmap_pbf);
        sndmap_rd = 1'b1;
        @(negedge clk);
        sndmap_rd = 1'b0;
        check_equal("sndmap_dout of last write", b2, sndmap_dout);
        check_equal("pbf after last read", 0, sndmap_pbf);
        finish_test();
    endtask

    initial begin
        rst_n      = 1'b0;
        main_cs    = 1'b0;
        main_addr  = '0;
        snd_cs     = 1'b0;
        snd_addr   = '0;
        sndmap_wr  = 1'b0;
        sndmap_din = '0;
        sndmap_rd  = 1'b0;
        errors     = 0;
        tests      = 0;
        timed_out  = 1'b0;
        test_name  = "reset";
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        count_clock_enables();
        start_test("main_rom");
        repeat (8) if (!timed_out) fetch_main(game_pkg::MAIN_AW'($random(seed)));
        finish_test();
        start_test("sound_rom");
        repeat (8) if (!timed_out) fetch_sound(game_pkg::SND_AW'($random(seed)));
        finish_test();
        if (!timed_out) check_cache_hit();
        // Both clients miss at the same time
        start_test("contention");
        repeat (6) begin
            if (!timed_out) begin
                pair_main_addr = game_pkg::MAIN_AW'($random(seed));
                pair_snd_addr  = game_pkg::SND_AW'($random(seed));
                fork
                    fetch_main(pair_main_addr);
                    fetch_sound(pair_snd_addr);
                join
            end
        end
        check_equal("reads left outstanding", 0, outstanding);
        finish_test();
        if (!timed_out) exercise_mailbox();

        $display("Summary: %0d tests run, %0d errors", tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
rtl/game_pkg.sv
rtl/cen_gen.sv
rtl/snd_mapper.sv
rtl/rom_slot.sv
rtl/bank_arb.sv
rtl/arcade_game.sv
tb/sdram_bank_model.sv
tb/tb_arcade_game.sv

// ==== Bender.yml ====
package:
  name: arcade_game

sources:
  - rtl/game_pkg.sv
  - rtl/cen_gen.sv
  - rtl/snd_mapper.sv
  - rtl/rom_slot.sv
  - rtl/bank_arb.sv
  - rtl/arcade_game.sv
  - target: test
    files:
      - tb/sdram_bank_model.sv
      - tb/tb_arcade_game.sv
